//--- Makefile
TOP := tb_cache_refill

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+verilog
verilog/refill_pkg.sv
verilog/icache_refill_ctrl.sv
verilog/dcache_miss_ctrl.sv
verilog/mem_read_arbiter.sv
verilog/cache_refill_subsys.sv
tb/cache_refill_properties.sv
tb/tb_cache_refill.sv

//--- tb/cache_refill_properties.sv
////////////////////////////////////////
// Bound into cache_refill_subsys, idle during reset
////////////////////////////////////////
`timescale 1ns/1ps

module cache_refill_properties (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_valid_i,
  input refill_pkg::mem_req_t req_i,
  input logic                 req_ready_i,
  input logic                 flush_ack_i,
  input logic                 ic_miss_valid_i,
  input logic                 ic_miss_ready_i,
  input logic                 ic_refill_valid_i
);

  logic ic_pending_q;

  // Accepted instruction miss awaiting its refill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ic_pending_q <= 1'b0;
    end else if (ic_miss_valid_i && ic_miss_ready_i) begin
      ic_pending_q <= 1'b1;
    end else if (ic_refill_valid_i) begin
      ic_pending_q <= 1'b0;
    end
  end

  // Held request while memory stalls
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else $error("memory request changed while waiting for ready");

  flush_ack_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_ack_i |=> !flush_ack_i)
    else $error("flush acknowledge high in two consecutive cycles");

  ic_ready_low_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_pending_q && !ic_refill_valid_i |-> !ic_miss_ready_i)
    else $error("instruction miss ready high with a request pending");

endmodule

bind cache_refill_subsys cache_refill_properties i_cache_refill_properties (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .req_valid_i       (mem_req_valid_o),
  .req_i             (mem_req_o),
  .req_ready_i       (mem_req_ready_i),
  .flush_ack_i       (dcache_flush_ack_o),
  .ic_miss_valid_i   (icache_miss_valid_i),
  .ic_miss_ready_i   (icache_miss_ready_o),
  .ic_refill_valid_i (icache_refill_o.valid)
);

//--- tb/tb_cache_refill.sv
////////////////////////////////////////
// Memory answers in random order after random delays.
// Expects four data entries and instruction read ID 4.
////////////////////////////////////////
`timescale 1ns/1ps
`include "refill_config.svh"

module tb_cache_refill;

  localparam int TIMEOUT_CYCLES = 20000;

  logic clk_i, rst_ni;
  logic icache_miss_valid_i, icache_miss_ready_o;
  logic dcache_miss_valid_i, dcache_miss_ready_o;
  logic dcache_flush_i, dcache_flush_ack_o;
  logic mem_req_valid_o, mem_req_ready_i;
  refill_pkg::miss_req_t  icache_miss_i, dcache_miss_i;
  refill_pkg::mem_req_t   mem_req_o, held_req;
  refill_pkg::mem_rsp_t   mem_rsp_i;
  refill_pkg::ic_refill_t icache_refill_o;
  refill_pkg::dc_refill_t dcache_refill_o;

  // Memory model and scoreboard
  refill_pkg::mem_req_t pend_q[$];
  refill_pkg::paddr_t   dc_out[$];
  refill_pkg::paddr_t   ic_addr;
  bit [(1 << `REFILL_ID_W)-1:0] id_busy;
  bit hold_rsp, ic_busy, held_valid, last_ic, other_held;
  int cycle_count, ack_count, rsp_delay;

  wire ic_waiting = i_cache_refill_subsys.ic_req_valid;
  wire dc_waiting = i_cache_refill_subsys.dc_req_valid;

  cache_refill_subsys i_cache_refill_subsys (.*);

  // Upper half is the address, lower half its inverse
  function automatic refill_pkg::line_data_t ref_data(input refill_pkg::paddr_t addr);
    return refill_pkg::line_data_t'({addr, ~addr});
  endfunction

  function automatic refill_pkg::paddr_t rand_addr();
    return refill_pkg::paddr_t'($urandom) & ~refill_pkg::paddr_t'(7);
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_data(input string name, input refill_pkg::line_data_t got,
                              input refill_pkg::line_data_t exp);
    if (got !== exp)
      stop_with_error($sformatf("ERR t=%0t %s got %h exp %h", $time, name, got, exp));
  endtask

  task automatic compare_addr(input string name, input refill_pkg::paddr_t got,
                              input refill_pkg::paddr_t exp);
    if (got !== exp)
      stop_with_error($sformatf("ERR t=%0t %s got %h exp %h", $time, name, got, exp));
  endtask

  task automatic compare_id(input string name, input refill_pkg::mem_id_t got,
                            input refill_pkg::mem_id_t exp);
    if (got !== exp)
      stop_with_error($sformatf("ERR t=%0t %s got %h exp %h", $time, name, got, exp));
  endtask

  task automatic issue_ic_miss(input refill_pkg::paddr_t addr);
    @(negedge clk_i);
    icache_miss_valid_i = 1'b1;
    icache_miss_i.addr = addr;
    do @(posedge clk_i); while (!icache_miss_ready_o);
    @(negedge clk_i);
    icache_miss_valid_i = 1'b0;
  endtask

  task automatic issue_dc_miss(input refill_pkg::paddr_t addr);
    @(negedge clk_i);
    dcache_miss_valid_i = 1'b1;
    dcache_miss_i.addr = addr;
    do @(posedge clk_i); while (!dcache_miss_ready_o);
    @(negedge clk_i);
    dcache_miss_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    do @(negedge clk_i); while (ic_busy || dc_out.size() != 0);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) stop_with_error("Timeout: refills did not complete in time");
  end

  // Responses to a random outstanding request
  initial begin : mem_responder
    int pick;
    mem_req_ready_i = 1'b0;
    mem_rsp_i = '0;
    forever begin
      @(negedge clk_i);
      mem_rsp_i = '0;
      mem_req_ready_i = ($urandom % 4) != 0;
      if (!hold_rsp && pend_q.size() != 0) begin
        if (rsp_delay == 0) begin
          pick = $urandom % pend_q.size();
          mem_rsp_i = '{valid: 1'b1, id: pend_q[pick].id, data: ref_data(pend_q[pick].addr)};
          id_busy[pend_q[pick].id] = 1'b0;
          pend_q.delete(pick);
          rsp_delay = $urandom % 8;
        end else begin
          rsp_delay--;
        end
      end
    end
  end

  always @(posedge clk_i) begin : request_monitor
    logic win_ic;
    if (rst_ni && held_valid) begin
      if (!mem_req_valid_o) stop_with_error("Memory request valid dropped before ready");
      compare_id("mem_req_o.id", mem_req_o.id, held_req.id);
      compare_addr("mem_req_o.addr", mem_req_o.addr, held_req.addr);
    end
    if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
      win_ic = mem_req_o.id[`REFILL_ID_W-1];
      if (id_busy[mem_req_o.id]) stop_with_error("Request reuses an ID still outstanding");
      if (win_ic) compare_id("mem_req_o.id", mem_req_o.id, refill_pkg::mem_id_t'(`REFILL_IC_RD_ID));
      else if (mem_req_o.id >= `REFILL_DC_ENTRIES) stop_with_error("Data request ID out of range");
      if (other_held && win_ic == last_ic && (last_ic ? dc_waiting : ic_waiting))
        stop_with_error("Arbiter granted one side twice while the other waited");
      id_busy[mem_req_o.id] = 1'b1;
      pend_q.push_back(mem_req_o);
      last_ic = win_ic;
      other_held = win_ic ? dc_waiting : ic_waiting;
    end else begin
      other_held = other_held & (last_ic ? dc_waiting : ic_waiting);
    end
    held_valid = rst_ni && mem_req_valid_o && !mem_req_ready_i;
    held_req = mem_req_o;
  end

  always @(posedge clk_i) begin : refill_check
    int idx;
    if (rst_ni) begin
      if (icache_refill_o.valid) begin
        if (!ic_busy) stop_with_error("Instruction refill without an outstanding miss");
        compare_data("icache_refill_o.data", icache_refill_o.data, ref_data(ic_addr));
        ic_busy = 1'b0;
      end
      if (dcache_refill_o.valid) begin
        idx = -1;
        foreach (dc_out[i]) begin
          if (idx < 0 && dc_out[i] == dcache_refill_o.addr) idx = i;
        end
        if (idx < 0) stop_with_error("Data refill for an address with no outstanding miss");
        compare_data("dcache_refill_o.data", dcache_refill_o.data, ref_data(dc_out[idx]));
        dc_out.delete(idx);
      end
      if (icache_miss_valid_i && icache_miss_ready_o) begin
        if (ic_busy) stop_with_error("Second instruction miss accepted before its refill");
        ic_busy = 1'b1;
        ic_addr = icache_miss_i.addr;
      end
      if (dcache_miss_valid_i && dcache_miss_ready_o) begin
        if (dcache_flush_i) stop_with_error("Data miss accepted while flush is high");
        dc_out.push_back(dcache_miss_i.addr);
      end
      if (dcache_flush_ack_o) begin
        if (!dcache_flush_i || dc_out.size() != 0)
          stop_with_error("Flush acknowledged without a flush or with misses outstanding");
        ack_count++;
      end
    end
  end

  initial begin
    void'($urandom(32'hef8f_ec33));
    rst_ni = 1'b0;
    icache_miss_valid_i = 1'b0;
    icache_miss_i = '0;
    dcache_miss_valid_i = 1'b0;
    dcache_miss_i = '0;
    dcache_flush_i = 1'b0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (40) issue_ic_miss(rand_addr());
    wait_drained();
    // Table fills while memory holds its answers
    @(posedge clk_i);
    hold_rsp = 1'b1;
    repeat (`REFILL_DC_ENTRIES) issue_dc_miss(rand_addr());
    @(posedge clk_i);
    if (dcache_miss_ready_o) stop_with_error("Data miss ready stayed high with the table full");
    hold_rsp = 1'b0;
    issue_dc_miss(rand_addr());
    fork
      repeat (150) begin
        repeat ($urandom % 3) @(negedge clk_i);
        issue_ic_miss(rand_addr());
      end
      repeat (200) begin
        repeat ($urandom % 3) @(negedge clk_i);
        issue_dc_miss(rand_addr());
      end
    join
    // Flush with data misses still in flight
    repeat (3) issue_dc_miss(rand_addr());
    @(negedge clk_i);
    dcache_flush_i = 1'b1;
    dcache_miss_valid_i = 1'b1;
    dcache_miss_i.addr = rand_addr();
    do @(posedge clk_i); while (!dcache_flush_ack_o);
    @(negedge clk_i);
    dcache_flush_i = 1'b0;
    dcache_miss_valid_i = 1'b0;
    wait_drained();
    repeat (4) @(negedge clk_i);
    if (ic_busy || dc_out.size() != 0 || ack_count != 1) begin
      stop_with_error("Run ended with refills missing or a wrong flush acknowledge count");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

//--- verilog/cache_refill_subsys.sv
////////////////////////////////////////
// Two miss controllers sharing one memory read port
////////////////////////////////////////
`timescale 1ns/1ps

module cache_refill_subsys (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   icache_miss_valid_i,
  input  refill_pkg::miss_req_t  icache_miss_i,
  output logic                   icache_miss_ready_o,
  input  logic                   dcache_miss_valid_i,
  input  refill_pkg::miss_req_t  dcache_miss_i,
  output logic                   dcache_miss_ready_o,
  input  logic                   dcache_flush_i,
  output logic                   dcache_flush_ack_o,
  output logic                   mem_req_valid_o,
  output refill_pkg::mem_req_t   mem_req_o,
  input  logic                   mem_req_ready_i,
  input  refill_pkg::mem_rsp_t   mem_rsp_i,
  output refill_pkg::ic_refill_t icache_refill_o,
  output refill_pkg::dc_refill_t dcache_refill_o
);

  logic                 ic_req_valid, ic_grant, ic_rsp_valid;
  logic                 dc_req_valid, dc_grant, dc_rsp_valid;
  refill_pkg::mem_req_t ic_req, dc_req;
  refill_pkg::mem_rsp_t rsp;

  icache_refill_ctrl i_icache_refill_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_valid_i (icache_miss_valid_i),
    .miss_i       (icache_miss_i),
    .miss_ready_o (icache_miss_ready_o),
    .req_valid_o  (ic_req_valid),
    .req_o        (ic_req),
    .req_grant_i  (ic_grant),
    .rsp_valid_i  (ic_rsp_valid),
    .rsp_i        (rsp),
    .refill_o     (icache_refill_o)
  );

  dcache_miss_ctrl i_dcache_miss_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_valid_i (dcache_miss_valid_i),
    .miss_i       (dcache_miss_i),
    .miss_ready_o (dcache_miss_ready_o),
    .flush_i      (dcache_flush_i),
    .flush_ack_o  (dcache_flush_ack_o),
    .req_valid_o  (dc_req_valid),
    .req_o        (dc_req),
    .req_grant_i  (dc_grant),
    .rsp_valid_i  (dc_rsp_valid),
    .rsp_i        (rsp),
    .refill_o     (dcache_refill_o)
  );

  mem_read_arbiter i_mem_read_arbiter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ic_req_valid_i  (ic_req_valid),
    .ic_req_i        (ic_req),
    .ic_grant_o      (ic_grant),
    .dc_req_valid_i  (dc_req_valid),
    .dc_req_i        (dc_req),
    .dc_grant_o      (dc_grant),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .ic_rsp_valid_o  (ic_rsp_valid),
    .dc_rsp_valid_o  (dc_rsp_valid),
    .rsp_o           (rsp)
  );

endmodule

//--- verilog/dcache_miss_ctrl.sv
////////////////////////////////////////
// Data-side miss table. Entry index is the memory ID.
// Flush blocks new misses until the table drains.
////////////////////////////////////////
`timescale 1ns/1ps
`include "refill_config.svh"

module dcache_miss_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   miss_valid_i,
  input  refill_pkg::miss_req_t  miss_i,
  output logic                   miss_ready_o,
  input  logic                   flush_i,
  output logic                   flush_ack_o,
  output logic                   req_valid_o,
  output refill_pkg::mem_req_t   req_o,
  input  logic                   req_grant_i,
  input  logic                   rsp_valid_i,
  input  refill_pkg::mem_rsp_t   rsp_i,
  output refill_pkg::dc_refill_t refill_o
);

  localparam int unsigned NUM_ENTRIES = `REFILL_DC_ENTRIES;
  localparam int unsigned IDX_W       = $clog2(NUM_ENTRIES);

  logic [NUM_ENTRIES-1:0] busy_q;
  logic [NUM_ENTRIES-1:0] issued_q;
  refill_pkg::paddr_t     addr_q [NUM_ENTRIES];

  // Issue order of allocated entries
  logic [IDX_W-1:0]       order_q [NUM_ENTRIES];
  logic [IDX_W-1:0]       wr_ptr_q, rd_ptr_q;
  logic [IDX_W:0]         count_q;

  logic [IDX_W-1:0]       alloc_idx, head_idx, rsp_idx;
  logic                   miss_fire, rsp_hit;
  logic                   flush_ack_q, refill_valid_q;
  refill_pkg::paddr_t     refill_addr_q;
  refill_pkg::line_data_t refill_data_q;

  // Lowest free entry
  always_comb begin
    alloc_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!busy_q[i]) alloc_idx = IDX_W'(i);
    end
  end

  assign miss_ready_o = ~(&busy_q) & ~flush_i;
  assign miss_fire    = miss_valid_i & miss_ready_o;

  assign head_idx    = order_q[rd_ptr_q];
  assign req_valid_o = (count_q != '0);
  assign req_o       = '{id: refill_pkg::mem_id_t'(head_idx), addr: addr_q[head_idx]};

  assign rsp_idx = rsp_i.id[IDX_W-1:0];
  assign rsp_hit = rsp_valid_i & busy_q[rsp_idx] & issued_q[rsp_idx];

  assign flush_ack_o = flush_ack_q;
  assign refill_o    = '{valid: refill_valid_q, addr: refill_addr_q, data: refill_data_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q         <= '0;
      issued_q       <= '0;
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      count_q        <= '0;
      flush_ack_q    <= 1'b0;
      refill_valid_q <= 1'b0;
    end else begin
      if (rsp_hit) begin
        busy_q[rsp_idx]   <= 1'b0;
        issued_q[rsp_idx] <= 1'b0;
      end
      if (req_grant_i) begin
        issued_q[head_idx] <= 1'b1;
        rd_ptr_q           <= rd_ptr_q + 1'b1;
      end
      if (miss_fire) begin
        busy_q[alloc_idx] <= 1'b1;
        wr_ptr_q          <= wr_ptr_q + 1'b1;
      end
      unique case ({miss_fire, req_grant_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Empty table acknowledges, never twice in a row
      flush_ack_q    <= flush_i & ~(|busy_q) & ~flush_ack_q;
      refill_valid_q <= rsp_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_fire) begin
      addr_q[alloc_idx] <= miss_i.addr;
      order_q[wr_ptr_q] <= alloc_idx;
    end
    if (rsp_hit) begin
      refill_addr_q <= addr_q[rsp_idx];
      refill_data_q <= rsp_i.data;
    end
  end

endmodule

//--- verilog/icache_refill_ctrl.sv
////////////////////////////////////////
// One outstanding instruction read, issued with REFILL_IC_RD_ID
////////////////////////////////////////
`timescale 1ns/1ps
`include "refill_config.svh"

module icache_refill_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   miss_valid_i,
  input  refill_pkg::miss_req_t  miss_i,
  output logic                   miss_ready_o,
  output logic                   req_valid_o,
  output refill_pkg::mem_req_t   req_o,
  input  logic                   req_grant_i,
  input  logic                   rsp_valid_i,
  input  refill_pkg::mem_rsp_t   rsp_i,
  output refill_pkg::ic_refill_t refill_o
);

  refill_pkg::ic_state_e  state_q, state_d;
  refill_pkg::paddr_t     addr_q;
  logic                   refill_valid_q;
  refill_pkg::line_data_t refill_data_q;

  assign miss_ready_o = (state_q == refill_pkg::IC_IDLE);
  assign req_valid_o  = (state_q == refill_pkg::IC_REQ);
  assign req_o        = '{id: refill_pkg::mem_id_t'(`REFILL_IC_RD_ID), addr: addr_q};
  assign refill_o     = '{valid: refill_valid_q, data: refill_data_q};

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      refill_pkg::IC_IDLE: begin
        if (miss_valid_i) state_d = refill_pkg::IC_REQ;
      end
      refill_pkg::IC_REQ: begin
        if (req_grant_i) state_d = refill_pkg::IC_WAIT;
      end
      refill_pkg::IC_WAIT: begin
        if (rsp_valid_i) state_d = refill_pkg::IC_IDLE;
      end
      default: state_d = refill_pkg::IC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= refill_pkg::IC_IDLE;
      refill_valid_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      refill_valid_q <= rsp_valid_i && (state_q == refill_pkg::IC_WAIT);
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_valid_i && miss_ready_o) addr_q <= miss_i.addr;
    if (rsp_valid_i) refill_data_q <= rsp_i.data;
  end

endmodule

//--- verilog/mem_read_arbiter.sv
////////////////////////////////////////
// Round-robin on the shared read port. IDs with the
// top bit set route back to the instruction side.
////////////////////////////////////////
`timescale 1ns/1ps
`include "refill_config.svh"

module mem_read_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ic_req_valid_i,
  input  refill_pkg::mem_req_t ic_req_i,
  output logic                 ic_grant_o,
  input  logic                 dc_req_valid_i,
  input  refill_pkg::mem_req_t dc_req_i,
  output logic                 dc_grant_o,
  output logic                 mem_req_valid_o,
  output refill_pkg::mem_req_t mem_req_o,
  input  logic                 mem_req_ready_i,
  input  refill_pkg::mem_rsp_t mem_rsp_i,
  output logic                 ic_rsp_valid_o,
  output logic                 dc_rsp_valid_o,
  output refill_pkg::mem_rsp_t rsp_o
);

  logic last_ic_q;
  logic lock_q, lock_ic_q;
  logic sel_ic;

  // Locked choice first, then alternate on contention
  always_comb begin
    if (lock_q) begin
      sel_ic = lock_ic_q;
    end else if (ic_req_valid_i && dc_req_valid_i) begin
      sel_ic = ~last_ic_q;
    end else begin
      sel_ic = ic_req_valid_i;
    end
  end

  assign mem_req_valid_o = ic_req_valid_i | dc_req_valid_i;
  assign mem_req_o       = sel_ic ? ic_req_i : dc_req_i;
  assign ic_grant_o      = sel_ic & ic_req_valid_i & mem_req_ready_i;
  assign dc_grant_o      = ~sel_ic & dc_req_valid_i & mem_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_ic_q <= 1'b0;
      lock_q    <= 1'b0;
      lock_ic_q <= 1'b0;
    end else begin
      lock_q    <= mem_req_valid_o & ~mem_req_ready_i;
      lock_ic_q <= sel_ic;
      if (mem_req_valid_o && mem_req_ready_i) last_ic_q <= sel_ic;
    end
  end

  assign ic_rsp_valid_o = mem_rsp_i.valid & mem_rsp_i.id[`REFILL_ID_W-1];
  assign dc_rsp_valid_o = mem_rsp_i.valid & ~mem_rsp_i.id[`REFILL_ID_W-1];
  assign rsp_o          = mem_rsp_i;

endmodule

//--- verilog/refill_config.svh
////////////////////////////////////////
// Refill path sizing. REFILL_DC_ENTRIES must be a power of two and
// below REFILL_IC_RD_ID, the only ID with the top bit set.
////////////////////////////////////////
`ifndef REFILL_CONFIG_SVH
`define REFILL_CONFIG_SVH

// Physical address and refill beat
`define REFILL_ADDR_W 32
`define REFILL_DATA_W 64

// Memory transaction ID
`define REFILL_ID_W 3

// Data-side outstanding misses
`define REFILL_DC_ENTRIES 4

// Fixed instruction read ID
`define REFILL_IC_RD_ID 4

`endif

//--- verilog/refill_pkg.sv
////////////////////////////////////////
// Types shared by the refill path. Widths come from refill_config.svh
////////////////////////////////////////
`include "refill_config.svh"

package refill_pkg;

  typedef logic [`REFILL_ADDR_W-1:0] paddr_t;
  typedef logic [`REFILL_DATA_W-1:0] line_data_t;
  typedef logic [`REFILL_ID_W-1:0]   mem_id_t;

  // Miss from a cache
  typedef struct packed {
    paddr_t addr;
  } miss_req_t;

  typedef struct packed {
    mem_id_t id;
    paddr_t  addr;
  } mem_req_t;

  // Single-beat read return
  typedef struct packed {
    logic       valid;
    mem_id_t    id;
    line_data_t data;
  } mem_rsp_t;

  typedef struct packed {
    logic       valid;
    line_data_t data;
  } ic_refill_t;

  typedef struct packed {
    logic       valid;
    paddr_t     addr;
    line_data_t data;
  } dc_refill_t;

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_REQ,
    IC_WAIT
  } ic_state_e;

endpackage
